//--- rtl/chitchat_link.sv
`timescale 1ns/10ps
`default_nettype none

module chitchat_link #(
   parameter logic [31:0] REV_ID = 32'h0   // Passed to the transmitter
) (
   input  wire                               clk,
   input  wire                               rst_n,
   input  wire chitchat_pkg::cc_tx_data_t    tx_in,
   input  wire chitchat_pkg::cc_lane_t       lane_in,       // From the far end
   output wire                               tx_enable,
   output wire  [15:0]                       local_frame_counter,
   output wire chitchat_pkg::cc_lane_t       lane_out,      // To the far end
   output wire                               rx_valid,
   output wire chitchat_pkg::cc_frame_t      rx_frame,
   output wire chitchat_pkg::cc_rx_fault_t   rx_fault
);

   // ------------------------------------------------------------------------
   // Transmit lane, far-end counter looped back into each frame
   // ------------------------------------------------------------------------
   chitchat_tx #(
      .REV_ID (REV_ID)
   ) u_tx (
      .clk                 (clk),
      .rst_n               (rst_n),
      .tx_in               (tx_in),
      .loopback_counter    (rx_frame.frame_counter),  // Last good far-end count
      .tx_enable           (tx_enable),
      .local_frame_counter (local_frame_counter),
      .lane_out            (lane_out)
   );

   // Receive lane
   chitchat_rx u_rx (
      .clk      (clk),
      .rst_n    (rst_n),
      .lane_in  (lane_in),
      .rx_valid (rx_valid),
      .rx_frame (rx_frame),
      .rx_fault (rx_fault)
   );

endmodule

`default_nettype wire

//--- rtl/chitchat_pkg.sv
`default_nettype none

package chitchat_pkg;

   // ------------------------------------------------------------------------
   // Protocol identification and framing constants
   // ------------------------------------------------------------------------
   localparam logic [3:0] cc_protocol_cat  = 4'h1;   // Word 0 bits 15:12
   localparam logic [3:0] cc_protocol_ver  = 4'h1;   // Word 0 bits 11:8
   localparam logic [2:0] cc_gateware_type = 3'h2;   // Word 1 bits 15:13
   localparam logic [7:0] cc_k28_5         = 8'hbc;  // Comma byte, low half of word 0

   // 16-bit words per frame, CRC in the last one
   localparam int unsigned cc_frame_words = 11;

   // CRC-16-CCITT seed, MSB first, no final XOR
   localparam logic [15:0] cc_crc_init = 16'hffff;

   // ------------------------------------------------------------------------
   // Link structures
   // ------------------------------------------------------------------------

   // Application inputs, sampled once per frame
   typedef struct packed {
      logic [2:0]  location;        // Position in the cryomodule
      logic [31:0] cavity0_status;
      logic [31:0] cavity1_status;
      logic        valid;           // Starts a frame when the link is idle
   } cc_tx_data_t;

   // Decoded frame as seen by the far end
   typedef struct packed {
      logic [2:0]  gateware_type;
      logic [2:0]  location;
      logic [31:0] rev_id;
      logic [31:0] cavity0_status;
      logic [31:0] cavity1_status;
      logic [15:0] frame_counter;     // Sender's local count
      logic [15:0] loopback_counter;  // Our own count, echoed back
   } cc_frame_t;

   // One transceiver word
   typedef struct packed {
      logic [15:0] data;
      logic        k;     // Comma in data[7:0]
   } cc_lane_t;

   // Receive faults, each a one-cycle pulse
   typedef struct packed {
      logic crc_err;     // CRC mismatch on word 10
      logic proto_err;   // Category or version mismatch
      logic align_err;   // Comma before word 10 arrived
   } cc_rx_fault_t;

endpackage

`default_nettype wire

//--- rtl/chitchat_rx.sv
`timescale 1ns/10ps
`default_nettype none

module chitchat_rx (
   input  wire                               clk,
   input  wire                               rst_n,
   input  wire chitchat_pkg::cc_lane_t       lane_in,
   output logic                              rx_valid,   // One cycle per good frame
   output chitchat_pkg::cc_frame_t           rx_frame,   // Held until the next good frame
   output chitchat_pkg::cc_rx_fault_t        rx_fault
);

   localparam logic [3:0] last_word = 4'(chitchat_pkg::cc_frame_words - 1);
   localparam int         buf_words = chitchat_pkg::cc_frame_words - 1;  // CRC not stored

   // ------------------------------------------------------------------------
   // Comma detect and word index
   // ------------------------------------------------------------------------
   logic       comma;     // Valid K28.5 on this cycle
   logic [3:0] idx;       // Index of the word now on lane_in, 0 when idle
   logic       active;
   logic       at_last;   // CRC word on lane_in

   assign comma   = lane_in.k && (lane_in.data[7:0] == chitchat_pkg::cc_k28_5);
   assign active  = (idx != 4'd0);
   assign at_last = active && (idx == last_word) && !comma;  // New comma wins

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         idx <= 4'd0;
      end else if (comma) begin
         idx <= 4'd1;                 // Comma is word 0, expect word 1 next
      end else if (at_last) begin
         idx <= 4'd0;                 // Frame done, back to hunting
      end else if (active) begin
         idx <= idx + 4'd1;
      end
   end

   // ------------------------------------------------------------------------
   // Word buffer and CRC
   // ------------------------------------------------------------------------
   logic [15:0] word_buf [0:buf_words-1];
   logic [15:0] crc_calc;

   always_ff @(posedge clk) begin
      if (comma) begin
         word_buf[0] <= lane_in.data;
      end else if (active && !at_last) begin
         word_buf[idx] <= lane_in.data;   // Words 1..9
      end
   end

   // Running CRC, restarted on the comma word
   crc16 u_crc (
      .clk   (clk),
      .rst_n (rst_n),
      .din   (lane_in.data),
      .zero  (comma),
      .crc   (crc_calc)
   );

   // ------------------------------------------------------------------------
   // Frame check and decode
   // ------------------------------------------------------------------------
   logic                    crc_ok;
   logic                    proto_ok;
   logic                    frame_ok;
   chitchat_pkg::cc_frame_t decoded;

   // crc_calc covers words 0..9 while word 10 is on the lane
   assign crc_ok   = (lane_in.data == crc_calc);
   assign proto_ok = (word_buf[0][15:12] == chitchat_pkg::cc_protocol_cat) &&
                     (word_buf[0][11:8]  == chitchat_pkg::cc_protocol_ver);
   assign frame_ok = at_last && crc_ok && proto_ok;

   always_comb begin
      decoded.gateware_type    = word_buf[1][15:13];
      decoded.location         = word_buf[1][12:10];  // Low 10 bits reserved
      decoded.rev_id           = {word_buf[2], word_buf[3]};
      decoded.cavity0_status   = {word_buf[4], word_buf[5]};
      decoded.cavity1_status   = {word_buf[6], word_buf[7]};
      decoded.frame_counter    = word_buf[8];
      decoded.loopback_counter = word_buf[9];
   end

   // Outputs, one cycle after word 10
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rx_valid <= 1'b0;
         rx_fault <= '0;
         rx_frame <= '0;
      end else begin
         rx_valid           <= frame_ok;
         rx_fault.crc_err   <= at_last && !crc_ok;             // CRC beats protocol
         rx_fault.proto_err <= at_last && crc_ok && !proto_ok;
         rx_fault.align_err <= comma && active;                // Truncated frame
         if (frame_ok) begin
            rx_frame <= decoded;
         end
      end
   end

   // Each frame ends in a strobe or a single fault, never a mix
   a_one_outcome : assert property (@(posedge clk) disable iff (!rst_n)
      $onehot0({rx_valid, rx_fault}));

endmodule

`default_nettype wire

//--- rtl/chitchat_tx.sv
`timescale 1ns/10ps
`default_nettype none

module chitchat_tx #(
   parameter logic [31:0] REV_ID = 32'h0   // Build ID carried in words 2 and 3
) (
   input  wire                               clk,
   input  wire                               rst_n,
   input  wire chitchat_pkg::cc_tx_data_t    tx_in,
   input  wire  [15:0]                       loopback_counter,  // From the receiver
   output logic                              tx_enable,         // Inputs sampled
   output logic [15:0]                       local_frame_counter,
   output chitchat_pkg::cc_lane_t            lane_out
);

   localparam int          frame_bits = chitchat_pkg::cc_frame_words * 16;
   localparam logic [3:0]  last_word  = 4'(chitchat_pkg::cc_frame_words - 1);
   localparam logic [3:0]  comma_pos  = 4'd4;   // Count value while the comma is on lane_out

   // ------------------------------------------------------------------------
   // Frame timing
   // ------------------------------------------------------------------------
   logic [3:0] word_count;   // 0 idle, 1..10 inside a frame
   logic       advance;
   logic       start;        // Load cycle, also tx_enable
   logic       sync;         // Word 0 at the shifter head
   logic       last;
   logic       last_r;
   logic       crc_time;     // Word 10 slot at the output register input

   assign advance = tx_in.valid || (word_count != 4'd0);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         word_count <= 4'd0;
         start      <= 1'b0;
         sync       <= 1'b0;
         last       <= 1'b0;
         last_r     <= 1'b0;
         crc_time   <= 1'b0;
      end else begin
         if (word_count == last_word) begin
            word_count <= 4'd0;                 // Wrap, restart only on valid
         end else if (advance) begin
            word_count <= word_count + 4'd1;
         end
         start    <= (word_count == 4'd1);
         sync     <= start;
         last     <= (word_count == last_word);
         last_r   <= last;
         crc_time <= last_r;
      end
   end

   // ------------------------------------------------------------------------
   // Frame shift register
   // ------------------------------------------------------------------------
   logic [15:0]           frame_counter;
   logic [frame_bits-1:0] frame;
   logic [frame_bits-1:0] frame_load;
   logic [15:0]           head;       // Word at the top of the shifter
   logic [15:0]           crc_tx;

   // Big-endian word order, CRC slot padded with zero
   assign frame_load = {chitchat_pkg::cc_protocol_cat,
                        chitchat_pkg::cc_protocol_ver,
                        chitchat_pkg::cc_k28_5,
                        chitchat_pkg::cc_gateware_type, tx_in.location, 10'd0,
                        REV_ID,
                        tx_in.cavity0_status,
                        tx_in.cavity1_status,
                        frame_counter,
                        loopback_counter,
                        16'h0000};

   assign head = frame[frame_bits-1 -: 16];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         frame_counter <= 16'd0;
         frame         <= '0;
      end else begin
         if (start) begin
            frame_counter <= frame_counter + 16'd1;  // Frame holds the old count
            frame         <= frame_load;
         end else begin
            frame <= {frame[frame_bits-17:0], 16'h0000};
         end
      end
   end

   crc16 u_crc (
      .clk   (clk),
      .rst_n (rst_n),
      .din   (head),
      .zero  (sync),     // Restart on word 0
      .crc   (crc_tx)
   );

   // Output register, CRC replaces the pad word
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         lane_out <= '0;
      end else begin
         lane_out.data <= crc_time ? crc_tx : head;
         lane_out.k    <= sync;                  // K bit trails sync by a stage
      end
   end

   assign tx_enable           = start;
   assign local_frame_counter = frame_counter;

   // Comma leaves only from its slot in the count
   a_comma_slot : assert property (@(posedge clk) disable iff (!rst_n)
      lane_out.k |-> (word_count == comma_pos));

endmodule

`default_nettype wire

//--- rtl/crc16.sv
`timescale 1ns/10ps
`default_nettype none

module crc16 (
   input  wire         clk,
   input  wire         rst_n,
   input  wire  [15:0] din,    // Word folded in this cycle
   input  wire         zero,   // Fold din into the seed, not the running value
   output logic [15:0] crc     // CRC of all words up to the previous cycle
);

   localparam logic [15:0] poly = 16'h1021;  // x^16 + x^12 + x^5 + 1

   // One full word through the serial LFSR, bit 15 first
   function automatic logic [15:0] crc_step(input logic [15:0] c_in,
                                            input logic [15:0] d);
      logic [15:0] c;
      logic        fb;
      c = c_in;
      for (int i = 15; i >= 0; i--) begin
         fb = c[15] ^ d[i];                          // Feedback tap
         c  = {c[14:0], 1'b0} ^ (fb ? poly : 16'h0000);
      end
      return c;
   endfunction

   logic [15:0] seed;

   // Restart picks the init value in place of the register
   assign seed = zero ? chitchat_pkg::cc_crc_init : crc;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         crc <= chitchat_pkg::cc_crc_init;
      end else begin
         crc <= crc_step(seed, din);
      end
   end

endmodule

`default_nettype wire

//--- sim.f
rtl/chitchat_pkg.sv
rtl/crc16.sv
rtl/chitchat_tx.sv
rtl/chitchat_rx.sv
rtl/chitchat_link.sv
verif/chitchat_clkgen.sv
verif/chitchat_link_tb.sv

//--- verif/chitchat_clkgen.sv
`timescale 1ns/10ps
`default_nettype none

module chitchat_clkgen #(
   parameter real half_period  = 20.0,   // 40 ns clock
   parameter int  reset_cycles = 16
) (
   output logic clk,
   output logic rst_n
);

   initial begin
      clk   = 1'b0;
      rst_n = 1'b0;                        // Low from time zero
      forever #(half_period) clk = ~clk;
   end

   // Release on a rising edge, like any other driven input
   initial begin
      repeat (reset_cycles) @(posedge clk);
      rst_n <= 1'b1;
   end

endmodule

`default_nettype wire

//--- verif/chitchat_link_tb.sv
`timescale 1ns/10ps
`default_nettype none

module chitchat_link_tb;

   localparam logic [31:0] rev_id     = 32'hc0de_5a17;
   localparam int          limit      = 40;      // Cycles allowed per wait
   localparam int          n_entries  = 12;
   localparam logic [1:0]  act_pass   = 2'd0;
   localparam logic [1:0]  act_flip   = 2'd1;    // One data bit inverted
   localparam logic [1:0]  act_drop   = 2'd2;    // Comma k bit removed
   localparam logic [1:0]  act_inject = 2'd3;    // Extra comma on word 5

   typedef struct packed {
      logic [2:0]  location;
      logic [31:0] status0;
      logic [31:0] status1;
      logic [1:0]  action;
      logic [3:0]  word;      // Flip target, 1..10
      logic [3:0]  bit_sel;
   } entry_t;

   logic                       clk;
   logic                       rst_n;
   chitchat_pkg::cc_tx_data_t  tx_in;
   chitchat_pkg::cc_lane_t     lane_in;
   chitchat_pkg::cc_lane_t     lane_out;
   logic                       tx_enable;
   logic [15:0]                local_frame_counter;
   logic                       rx_valid;
   chitchat_pkg::cc_frame_t    rx_frame;
   chitchat_pkg::cc_rx_fault_t rx_fault;

   entry_t      stim [0:n_entries-1];
   entry_t      cur;         // Entry now on the channel
   logic [3:0]  pos;         // Word index on lane_out, from its comma
   logic [15:0] lane_crc;    // Word 10 as sent
   logic [15:0] tx_count;    // Local frame counter model
   logic [15:0] last_fc;     // Far-end counter seen by the transmitter
   int          checks;
   int          errors;
   integer      seed;

   chitchat_clkgen u_clkgen (.clk (clk), .rst_n (rst_n));

   chitchat_link #(.REV_ID (rev_id)) u_chitchat_link (
      .clk (clk), .rst_n (rst_n), .tx_in (tx_in), .lane_in (lane_in),
      .tx_enable (tx_enable), .local_frame_counter (local_frame_counter),
      .lane_out (lane_out), .rx_valid (rx_valid), .rx_frame (rx_frame),
      .rx_fault (rx_fault)
   );

   // ------------------------------------------------------------------------
   // Channel model, zero delay, one fault per entry
   always @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pos <= 4'd0;
      end else begin
         pos <= lane_out.k ? 4'd1 : ((pos != 4'd0 && pos != 4'd10) ? pos + 4'd1 : 4'd0);
      end
   end

   always_comb begin
      lane_in = lane_out;
      case (cur.action)
         act_flip:   if (pos == cur.word) lane_in.data = lane_out.data ^ (16'h1 << cur.bit_sel);
         act_drop:   lane_in.k = 1'b0;
         act_inject: if (pos == 4'd5) begin
            lane_in.k         = 1'b1;                       // Comma mid-frame
            lane_in.data[7:0] = chitchat_pkg::cc_k28_5;
         end
         default:    lane_in = lane_out;
      endcase
   end

   always @(negedge clk) begin
      if (pos == 4'd10) begin
         lane_crc <= lane_out.data;   // CRC slot before the channel
      end
   end

   // ------------------------------------------------------------------------
   task automatic check_value(input string name, input logic [191:0] exp,
                              input logic [191:0] act);
      checks++;
      if (exp !== act) begin
         errors++;
         $display("Error: %s expected %0h actual %0h", name, exp, act);
      end
   endtask

   // CCITT over the whole bit stream, MSB first
   function automatic logic [15:0] crc_ccitt(input logic [159:0] bits);
      logic [15:0] c;
      c = chitchat_pkg::cc_crc_init;
      for (int i = 159; i >= 0; i--) begin
         c = {c[14:0], 1'b0} ^ ((c[15] ^ bits[i]) ? 16'h1021 : 16'h0000);
      end
      return c;
   endfunction

   function automatic entry_t make_entry(input logic [2:0] loc, input logic [31:0] s0,
      input logic [31:0] s1, input logic [1:0] act, input logic [3:0] word,
      input logic [3:0] bit_sel);
      return '{location: loc, status0: s0, status1: s1, action: act, word: word,
               bit_sel: bit_sel};
   endfunction

   // Counts negedges until a strobe or fault shows
   task automatic wait_outcome(inout int lat, output bit seen);
      seen = 1'b0;
      for (int n = 0; n < limit && !seen; n++) begin
         @(negedge clk);
         lat++;
         seen = rx_valid || (rx_fault != '0);
      end
   endtask

   task automatic run_entry(input int i);
      string                   name;
      logic [15:0]             fc_exp;
      logic [15:0]             lb_exp;
      chitchat_pkg::cc_frame_t exp_frame;
      int                      lat;
      bit                      seen;
      name = $sformatf("entry%0d", i);
      @(posedge clk);
      cur   <= stim[i];
      tx_in <= {stim[i].location, stim[i].status0, stim[i].status1, 1'b1};
      seen = 1'b0;
      for (int n = 0; n < limit && !seen; n++) begin
         @(negedge clk);
         seen = tx_enable;
      end
      if (!seen) begin
         $display("Timeout: %s never raised tx_enable", name);
         errors++;
         return;
      end
      fc_exp = tx_count;
      lb_exp = last_fc;                          // Loopback value at sampling
      check_value({name, "_count_at_enable"}, fc_exp, local_frame_counter);
      @(posedge clk);
      tx_in.valid <= 1'b0;                       // Sampling edge
      tx_count = tx_count + 16'd1;
      @(negedge clk);
      check_value({name, "_count_after"}, tx_count, local_frame_counter);
      lat = 1;
      wait_outcome(lat, seen);
      if (!seen && stim[i].action != act_drop) begin
         $display("Timeout: no strobe or fault for %s within %0d cycles", name, limit);
         errors++;
      end
      exp_frame = '{gateware_type: chitchat_pkg::cc_gateware_type,
                    location: stim[i].location, rev_id: rev_id,
                    cavity0_status: stim[i].status0, cavity1_status: stim[i].status1,
                    frame_counter: fc_exp, loopback_counter: lb_exp};
      case (stim[i].action)
         act_pass: begin
            check_value({name, "_latency"}, 13, lat);
            check_value({name, "_rx_valid"}, 1, rx_valid);
            check_value({name, "_rx_frame"}, exp_frame, rx_frame);
            last_fc = fc_exp;                    // Now looped back
         end
         act_flip: begin
            check_value({name, "_crc_err"}, 3'b100, {rx_fault, rx_valid} >> 1);
            check_value({name, "_rx_valid"}, 0, rx_valid);
         end
         act_drop:   check_value({name, "_no_outcome"}, 0, seen);
         default: begin
            check_value({name, "_align_err"}, 1, rx_fault.align_err);
            wait_outcome(lat, seen);             // Ghost frame ends on idle words
            if (!seen) begin
               $display("Timeout: frame after the extra comma never ended in %s", name);
               errors++;
            end
            check_value({name, "_ghost_valid"}, 0, rx_valid);
         end
      endcase
      check_value({name, "_crc_word"}, crc_ccitt({chitchat_pkg::cc_protocol_cat,
         chitchat_pkg::cc_protocol_ver, chitchat_pkg::cc_k28_5,
         chitchat_pkg::cc_gateware_type, stim[i].location, 10'd0, rev_id,
         stim[i].status0, stim[i].status1, fc_exp, lb_exp}), lane_crc);
   endtask

   // ------------------------------------------------------------------------
   initial begin
      tx_in    = '0;
      cur      = '0;                             // Pass-through channel
      checks   = 0;
      errors   = 0;
      tx_count = 16'd0;
      last_fc  = 16'd0;
      seed     = 32'h37d3f90e;
      stim[0]  = make_entry(3'd1, 32'h0000_0001, 32'hffff_0000, act_pass, 4'd0, 4'd0);
      stim[1]  = make_entry(3'd2, 32'ha5a5_5a5a, 32'h1234_5678, act_pass, 4'd0, 4'd0);
      stim[2]  = make_entry(3'd3, 32'hdead_beef, 32'h0bad_f00d, act_flip, 4'd3, 4'd7);
      stim[3]  = make_entry(3'd4, 32'h1111_2222, 32'h3333_4444, act_pass, 4'd0, 4'd0);
      stim[4]  = make_entry(3'd5, 32'h5555_aaaa, 32'h0f0f_f0f0, act_drop, 4'd0, 4'd0);
      stim[5]  = make_entry(3'd6, 32'h7654_3210, 32'hfedc_ba98, act_pass, 4'd0, 4'd0);
      stim[6]  = make_entry(3'd7, 32'hcafe_0001, 32'hcafe_0002, act_inject, 4'd0, 4'd0);
      stim[7]  = make_entry(3'd0, 32'h8000_0001, 32'h0000_8000, act_pass, 4'd0, 4'd0);
      stim[8]  = make_entry(3'd1, 32'h2468_ace0, 32'h1357_9bdf, act_flip, 4'd10, 4'd0);
      for (int i = 9; i < n_entries; i++) begin
         stim[i] = make_entry(3'($random(seed)), $random(seed), $random(seed),
                              act_pass, 4'd0, 4'd0);
      end
      for (int n = 0; n < limit && !rst_n; n++) begin
         @(negedge clk);
      end
      if (!rst_n) begin
         $display("Reset was never released");
         errors++;
      end else begin
         @(negedge clk);
         check_value("reset_state", 0, {tx_enable, lane_out, local_frame_counter,
                                        rx_valid, rx_fault});
         for (int n = 0; n < 20; n++) begin
            @(negedge clk);
            check_value("idle_outputs", 0, {lane_out.k, rx_valid, rx_fault});
         end
         for (int i = 0; i < n_entries; i++) begin
            run_entry(i);
         end
      end
      $display("Checks: %0d  errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire
